// File: core_settings.svh
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// data path and pc width
`define CORE_XLEN 32

// integer register file
`define CORE_REG_COUNT 32
`define CORE_REG_AW 5

// default instruction memory word-address width
`define CORE_IMEM_AW 10

// first fetch address
`define CORE_RESET_PC 32'h0000_0000

// addi x0, x0, 0
`define CORE_NOP 32'h0000_0013

`endif

// File: core_pkg.sv
`include "core_settings.svh"

package core_pkg;

  // major opcodes of the supported rv32i subset
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_AUIPC  = 7'b0010111,
    OPC_JAL    = 7'b1101111,
    OPC_JALR   = 7'b1100111,
    OPC_BRANCH = 7'b1100011
  } opcode_e;

  // alu operations, the last six only drive the branch condition
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_SLL  = 4'd2,
    ALU_SLT  = 4'd3,
    ALU_SLTU = 4'd4,
    ALU_XOR  = 4'd5,
    ALU_SRL  = 4'd6,
    ALU_SRA  = 4'd7,
    ALU_OR   = 4'd8,
    ALU_AND  = 4'd9,
    ALU_BEQ  = 4'd10,
    ALU_BNE  = 4'd11,
    ALU_BLT  = 4'd12,
    ALU_BGE  = 4'd13,
    ALU_BLTU = 4'd14,
    ALU_BGEU = 4'd15
  } alu_op_e;

  // execute operand source
  typedef enum logic {
    FWD_NONE = 1'b0,
    FWD_WB   = 1'b1
  } fwd_sel_e;

  // alu operand a source
  typedef enum logic [1:0] {
    A_SRC_REG  = 2'd0,
    A_SRC_ZERO = 2'd1,
    A_SRC_PC   = 2'd2
  } a_src_e;

  typedef struct packed {
    alu_op_e                 alu_op;
    a_src_e                  a_src;
    logic                    b_is_imm;
    logic                    reg_write;
    logic                    is_branch;
    logic                    is_jal;
    logic                    is_jalr;
    // 0 selects the alu result, 1 the link address
    logic                    wb_sel;
    logic [`CORE_REG_AW-1:0] rd_addr;
    logic [`CORE_REG_AW-1:0] rs1_addr;
    logic [`CORE_REG_AW-1:0] rs2_addr;
  } ctrl_t;

  typedef struct packed {
    logic                    valid;
    logic [`CORE_XLEN-1:0]   pc;
    logic [`CORE_XLEN-1:0]   insn;
    logic [`CORE_REG_AW-1:0] rd_addr;
    logic [`CORE_XLEN-1:0]   rd_wdata;
  } retire_t;

endpackage

// File: insn_decoder.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module insn_decoder (
  input  logic [`CORE_XLEN-1:0] insn_i,
  output core_pkg::ctrl_t       ctrl_o,
  output logic [`CORE_XLEN-1:0] imm_o
);
  import core_pkg::*;

  typedef enum logic [1:0] {
    IMM_I,
    IMM_B,
    IMM_U,
    IMM_J
  } imm_fmt_e;

  opcode_e                 opcode;
  logic [2:0]              funct3;
  logic                    funct7_b5;
  logic [`CORE_REG_AW-1:0] rd_field;
  logic [`CORE_REG_AW-1:0] rs1_field;
  logic [`CORE_REG_AW-1:0] rs2_field;
  imm_fmt_e                imm_fmt;
  alu_op_e                 arith_op;
  alu_op_e                 cmp_op;
  logic                    cmp_ok;

  assign opcode    = opcode_e'(insn_i[6:0]);
  assign funct3    = insn_i[14:12];
  assign funct7_b5 = insn_i[30];
  assign rd_field  = insn_i[11:7];
  assign rs1_field = insn_i[19:15];
  assign rs2_field = insn_i[24:20];

  // op and op_imm share funct3, sub only exists in the register form
  always_comb begin
    unique case (funct3)
      3'b000: arith_op = (opcode == OPC_OP && funct7_b5) ? ALU_SUB : ALU_ADD;
      3'b001: arith_op = ALU_SLL;
      3'b010: arith_op = ALU_SLT;
      3'b011: arith_op = ALU_SLTU;
      3'b100: arith_op = ALU_XOR;
      3'b101: arith_op = funct7_b5 ? ALU_SRA : ALU_SRL;
      3'b110: arith_op = ALU_OR;
      3'b111: arith_op = ALU_AND;
    endcase
  end

  // branch compares, funct3 010 and 011 are not branches
  always_comb begin
    cmp_op = ALU_BEQ;
    cmp_ok = 1'b1;
    case (funct3)
      3'b000:  cmp_op = ALU_BEQ;
      3'b001:  cmp_op = ALU_BNE;
      3'b100:  cmp_op = ALU_BLT;
      3'b101:  cmp_op = ALU_BGE;
      3'b110:  cmp_op = ALU_BLTU;
      3'b111:  cmp_op = ALU_BGEU;
      default: cmp_ok = 1'b0;
    endcase
  end

  // unknown opcodes keep the all-zero control word and retire as a nop
  always_comb begin
    ctrl_o  = '0;
    imm_fmt = IMM_I;
    case (opcode)
      OPC_OP: begin
        ctrl_o.alu_op    = arith_op;
        ctrl_o.reg_write = 1'b1;
        ctrl_o.rd_addr   = rd_field;
        ctrl_o.rs1_addr  = rs1_field;
        ctrl_o.rs2_addr  = rs2_field;
      end
      OPC_OP_IMM: begin
        ctrl_o.alu_op    = arith_op;
        ctrl_o.b_is_imm  = 1'b1;
        ctrl_o.reg_write = 1'b1;
        ctrl_o.rd_addr   = rd_field;
        ctrl_o.rs1_addr  = rs1_field;
      end
      OPC_LUI, OPC_AUIPC: begin
        ctrl_o.a_src     = (opcode == OPC_LUI) ? A_SRC_ZERO : A_SRC_PC;
        ctrl_o.b_is_imm  = 1'b1;
        ctrl_o.reg_write = 1'b1;
        ctrl_o.rd_addr   = rd_field;
        imm_fmt          = IMM_U;
      end
      OPC_JAL: begin
        ctrl_o.is_jal    = 1'b1;
        ctrl_o.reg_write = 1'b1;
        ctrl_o.wb_sel    = 1'b1;
        ctrl_o.rd_addr   = rd_field;
        imm_fmt          = IMM_J;
      end
      OPC_JALR: begin
        ctrl_o.is_jalr   = 1'b1;
        ctrl_o.reg_write = 1'b1;
        ctrl_o.wb_sel    = 1'b1;
        ctrl_o.rd_addr   = rd_field;
        ctrl_o.rs1_addr  = rs1_field;
      end
      OPC_BRANCH: begin
        ctrl_o.alu_op    = cmp_op;
        ctrl_o.is_branch = cmp_ok;
        ctrl_o.rs1_addr  = rs1_field;
        ctrl_o.rs2_addr  = rs2_field;
        imm_fmt          = IMM_B;
      end
      default: ;
    endcase
  end

  always_comb begin
    unique case (imm_fmt)
      IMM_I: imm_o = {{20{insn_i[31]}}, insn_i[31:20]};
      IMM_B: imm_o = {{20{insn_i[31]}}, insn_i[7], insn_i[30:25], insn_i[11:8], 1'b0};
      IMM_U: imm_o = {insn_i[31:12], 12'b0};
      IMM_J: imm_o = {{12{insn_i[31]}}, insn_i[19:12], insn_i[20], insn_i[30:21], 1'b0};
    endcase
  end

endmodule

// File: reg_file.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module reg_file (
  input  logic                    clk_i,
  input  logic                    rst_i,
  input  logic [`CORE_REG_AW-1:0] rs1_addr_i,
  input  logic [`CORE_REG_AW-1:0] rs2_addr_i,
  input  logic [`CORE_REG_AW-1:0] rd_addr_i,
  input  logic                    rd_we_i,
  input  logic [`CORE_XLEN-1:0]   rd_wdata_i,
  output logic [`CORE_XLEN-1:0]   rs1_rdata_o,
  output logic [`CORE_XLEN-1:0]   rs2_rdata_o
);

  logic [`CORE_XLEN-1:0] regs [`CORE_REG_COUNT];
  logic                  wr_en;

  // x0 is never written, so it keeps its reset value of zero
  assign wr_en = rd_we_i && (rd_addr_i != '0);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 0; i < `CORE_REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_en) begin
      regs[rd_addr_i] <= rd_wdata_i;
    end
  end

  // write-through, decode sees the value retiring in this cycle
  assign rs1_rdata_o = (wr_en && rd_addr_i == rs1_addr_i) ? rd_wdata_i : regs[rs1_addr_i];
  assign rs2_rdata_o = (wr_en && rd_addr_i == rs2_addr_i) ? rd_wdata_i : regs[rs2_addr_i];

endmodule

// File: alu.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module alu (
  input  logic [`CORE_XLEN-1:0] a_i,
  input  logic [`CORE_XLEN-1:0] b_i,
  input  core_pkg::alu_op_e     op_i,
  output logic [`CORE_XLEN-1:0] result_o,
  output logic                  branch_cond_o
);
  import core_pkg::*;

  localparam int SHAMT_W = $clog2(`CORE_XLEN);

  logic               eq;
  logic               lt_s;
  logic               lt_u;
  logic [SHAMT_W-1:0] shamt;

  // one set of comparators serves slt, sltu and all branches
  assign eq    = (a_i == b_i);
  assign lt_s  = ($signed(a_i) < $signed(b_i));
  assign lt_u  = (a_i < b_i);
  assign shamt = b_i[SHAMT_W-1:0];

  always_comb begin
    result_o      = '0;
    branch_cond_o = 1'b0;
    case (op_i)
      ALU_ADD:  result_o = a_i + b_i;
      ALU_SUB:  result_o = a_i - b_i;
      ALU_SLL:  result_o = a_i << shamt;
      ALU_SLT:  result_o = {{(`CORE_XLEN-1){1'b0}}, lt_s};
      ALU_SLTU: result_o = {{(`CORE_XLEN-1){1'b0}}, lt_u};
      ALU_XOR:  result_o = a_i ^ b_i;
      ALU_SRL:  result_o = a_i >> shamt;
      ALU_SRA:  result_o = $signed(a_i) >>> shamt;
      ALU_OR:   result_o = a_i | b_i;
      ALU_AND:  result_o = a_i & b_i;
      ALU_BEQ:  branch_cond_o = eq;
      ALU_BNE:  branch_cond_o = !eq;
      ALU_BLT:  branch_cond_o = lt_s;
      ALU_BGE:  branch_cond_o = !lt_s;
      ALU_BLTU: branch_cond_o = lt_u;
      ALU_BGEU: branch_cond_o = !lt_u;
    endcase
  end

endmodule

// File: hazard_unit.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module hazard_unit (
  input  logic [`CORE_REG_AW-1:0] ex_rs1_addr_i,
  input  logic [`CORE_REG_AW-1:0] ex_rs2_addr_i,
  input  logic [`CORE_REG_AW-1:0] wb_rd_addr_i,
  input  logic                    wb_reg_write_i,
  input  logic                    ex_taken_i,
  output core_pkg::fwd_sel_e      fwd_a_o,
  output core_pkg::fwd_sel_e      fwd_b_o,
  output logic                    flush_o
);
  import core_pkg::*;

  // forward when writeback is about to write the register execute reads
  function automatic fwd_sel_e src_fwd(
    input logic [`CORE_REG_AW-1:0] src_addr,
    input logic [`CORE_REG_AW-1:0] wb_addr,
    input logic                    wb_we
  );
    logic hit;
    hit = wb_we && (src_addr != '0) && (src_addr == wb_addr);
    return hit ? FWD_WB : FWD_NONE;
  endfunction

  assign fwd_a_o = src_fwd(ex_rs1_addr_i, wb_rd_addr_i, wb_reg_write_i);
  assign fwd_b_o = src_fwd(ex_rs2_addr_i, wb_rd_addr_i, wb_reg_write_i);

  // older instructions are needed later, only fetch and decode
  // hold wrong-path work when execute redirects
  assign flush_o = ex_taken_i;

endmodule

// File: pipe_core.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module pipe_core #(
  parameter int IMEM_AW = `CORE_IMEM_AW
) (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  logic [`CORE_XLEN-1:0] imem_rdata_i,
  output logic [IMEM_AW-1:0]    imem_addr_o,
  output core_pkg::retire_t     retire_o
);
  import core_pkg::*;

  logic [`CORE_XLEN-1:0]   if_pc;
  logic [`CORE_XLEN-1:0]   if_pc_plus4;
  logic [`CORE_XLEN-1:0]   if_pc_next;

  logic [`CORE_XLEN-1:0]   id_insn;
  logic [`CORE_XLEN-1:0]   id_pc;
  logic                    id_valid;
  ctrl_t                   id_ctrl;
  logic [`CORE_XLEN-1:0]   id_imm;
  logic [`CORE_XLEN-1:0]   id_rs1_data;
  logic [`CORE_XLEN-1:0]   id_rs2_data;

  ctrl_t                   ex_ctrl;
  logic [`CORE_XLEN-1:0]   ex_rs1_data;
  logic [`CORE_XLEN-1:0]   ex_rs2_data;
  logic [`CORE_XLEN-1:0]   ex_imm;
  logic [`CORE_XLEN-1:0]   ex_pc;
  logic [`CORE_XLEN-1:0]   ex_insn;
  logic                    ex_valid;
  fwd_sel_e                fwd_a;
  fwd_sel_e                fwd_b;
  logic [`CORE_XLEN-1:0]   ex_rs1;
  logic [`CORE_XLEN-1:0]   ex_rs2;
  logic [`CORE_XLEN-1:0]   ex_alu_a;
  logic [`CORE_XLEN-1:0]   ex_alu_b;
  logic [`CORE_XLEN-1:0]   ex_alu_result;
  logic                    ex_branch_cond;
  logic [`CORE_XLEN-1:0]   ex_target_sum;
  logic [`CORE_XLEN-1:0]   ex_target;
  logic                    ex_taken;
  logic [`CORE_XLEN-1:0]   ex_pc_plus4;
  logic [`CORE_XLEN-1:0]   ex_result;
  logic                    ex_reg_write;
  logic [`CORE_REG_AW-1:0] ex_rd_addr;
  logic                    flush;

  retire_t                 wb_retire;
  logic                    wb_reg_write;

  //////////////////////////////////////////////////////////////////////////
  // fetch
  //////////////////////////////////////////////////////////////////////////

  assign if_pc_plus4 = if_pc + 4;
  assign if_pc_next  = flush ? ex_target : if_pc_plus4;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      if_pc <= `CORE_RESET_PC;
    end else begin
      if_pc <= if_pc_next;
    end
  end

  // word address into the instruction memory
  assign imem_addr_o = if_pc[IMEM_AW+1:2];

  always_ff @(posedge clk_i) begin
    if (rst_i || flush) begin
      id_insn  <= `CORE_NOP;
      id_valid <= 1'b0;
    end else begin
      id_insn  <= imem_rdata_i;
      id_pc    <= if_pc;
      id_valid <= 1'b1;
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // decode
  //////////////////////////////////////////////////////////////////////////

  insn_decoder u_decoder (
    .insn_i (id_insn),
    .ctrl_o (id_ctrl),
    .imm_o  (id_imm)
  );

  reg_file u_reg_file (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .rs1_addr_i  (id_ctrl.rs1_addr),
    .rs2_addr_i  (id_ctrl.rs2_addr),
    .rd_addr_i   (wb_retire.rd_addr),
    .rd_we_i     (wb_reg_write),
    .rd_wdata_i  (wb_retire.rd_wdata),
    .rs1_rdata_o (id_rs1_data),
    .rs2_rdata_o (id_rs2_data)
  );

  always_ff @(posedge clk_i) begin
    if (rst_i || flush) begin
      ex_ctrl  <= '0;
      ex_insn  <= `CORE_NOP;
      ex_valid <= 1'b0;
    end else begin
      ex_ctrl     <= id_ctrl;
      ex_rs1_data <= id_rs1_data;
      ex_rs2_data <= id_rs2_data;
      ex_imm      <= id_imm;
      ex_pc       <= id_pc;
      ex_insn     <= id_insn;
      ex_valid    <= id_valid;
    end
  end

  //////////////////////////////////////////////////////////////////////////
  // execute
  //////////////////////////////////////////////////////////////////////////

  hazard_unit u_hazard (
    .ex_rs1_addr_i  (ex_ctrl.rs1_addr),
    .ex_rs2_addr_i  (ex_ctrl.rs2_addr),
    .wb_rd_addr_i   (wb_retire.rd_addr),
    .wb_reg_write_i (wb_reg_write),
    .ex_taken_i     (ex_taken),
    .fwd_a_o        (fwd_a),
    .fwd_b_o        (fwd_b),
    .flush_o        (flush)
  );

  assign ex_rs1 = (fwd_a == FWD_WB) ? wb_retire.rd_wdata : ex_rs1_data;
  assign ex_rs2 = (fwd_b == FWD_WB) ? wb_retire.rd_wdata : ex_rs2_data;

  always_comb begin
    case (ex_ctrl.a_src)
      A_SRC_REG: ex_alu_a = ex_rs1;
      A_SRC_PC:  ex_alu_a = ex_pc;
      default:   ex_alu_a = '0;
    endcase
  end

  assign ex_alu_b = ex_ctrl.b_is_imm ? ex_imm : ex_rs2;

  alu u_alu (
    .a_i           (ex_alu_a),
    .b_i           (ex_alu_b),
    .op_i          (ex_ctrl.alu_op),
    .result_o      (ex_alu_result),
    .branch_cond_o (ex_branch_cond)
  );

  // jalr adds to rs1 and drops bit 0, branches and jal add to pc
  assign ex_target_sum = (ex_ctrl.is_jalr ? ex_rs1 : ex_pc) + ex_imm;
  assign ex_target     = {ex_target_sum[`CORE_XLEN-1:1],
                          ex_target_sum[0] & ~ex_ctrl.is_jalr};

  assign ex_taken = ex_valid &&
                    (ex_ctrl.is_jal || ex_ctrl.is_jalr ||
                     (ex_ctrl.is_branch && ex_branch_cond));

  assign ex_pc_plus4  = ex_pc + 4;
  assign ex_result    = ex_ctrl.wb_sel ? ex_pc_plus4 : ex_alu_result;
  assign ex_reg_write = ex_valid && ex_ctrl.reg_write;
  assign ex_rd_addr   = ex_reg_write ? ex_ctrl.rd_addr : '0;

  //////////////////////////////////////////////////////////////////////////
  // writeback
  //////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wb_retire    <= '0;
      wb_reg_write <= 1'b0;
    end else begin
      wb_retire.valid    <= ex_valid;
      wb_retire.pc       <= ex_pc;
      wb_retire.insn     <= ex_insn;
      wb_retire.rd_addr  <= ex_rd_addr;
      // x0 destinations report a zero write value
      wb_retire.rd_wdata <= (ex_rd_addr != '0) ? ex_result : '0;
      wb_reg_write       <= ex_reg_write;
    end
  end

  assign retire_o = wb_retire;

endmodule

// File: core_props.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module core_props (
  input logic                     clk_i,
  input logic                     rst_i,
  input logic [`CORE_IMEM_AW-1:0] imem_addr_i,
  input core_pkg::retire_t        retire_i
);

  // jal x0, 0
  localparam logic [`CORE_XLEN-1:0] SELF_JUMP = 32'h0000_006f;

  logic [`CORE_XLEN-1:0] last_pc;
  logic                  have_last;
  int                    reset_errs = 0;
  int                    x0_errs = 0;
  int                    pc_errs = 0;

  // pc of the most recent valid retire
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      last_pc   <= '0;
      have_last <= 1'b0;
    end else if (retire_i.valid) begin
      last_pc   <= retire_i.pc;
      have_last <= 1'b1;
    end
  end

  // quiet retire port and fetch from address zero during and right after reset
  reset_state: assert property (@(posedge clk_i)
    rst_i |=> (!retire_i.valid && imem_addr_i == '0))
  else begin
    $error("retire valid or fetch address not cleared by reset");
    reset_errs++;
  end

  x0_zero_data: assert property (@(posedge clk_i) disable iff (rst_i)
    (retire_i.valid && retire_i.rd_addr == '0) |-> retire_i.rd_wdata == '0)
  else begin
    $error("retire to x0 carries a nonzero write value");
    x0_errs++;
  end

  // only the self jump may retire twice in a row from one pc
  no_pc_repeat: assert property (@(posedge clk_i) disable iff (rst_i)
    (retire_i.valid && have_last) |-> (retire_i.pc != last_pc || retire_i.insn == SELF_JUMP))
  else begin
    $error("two consecutive retires share one pc");
    pc_errs++;
  end

endmodule

// File: tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk_o,
  output logic rst_o
);

  // 20 ns period
  initial begin
    clk_o = 1'b0;
    forever #10 clk_o = ~clk_o;
  end

  // reset spans two rising edges and drops on a falling edge
  initial begin
    rst_o = 1'b1;
    repeat (2) @(posedge clk_o);
    @(negedge clk_o);
    rst_o = 1'b0;
  end

endmodule

// File: tb_core.sv
`timescale 1ns/1ps
`include "core_settings.svh"

module tb_core;
  import core_pkg::*;

  localparam int IMEM_WORDS     = 1 << `CORE_IMEM_AW;
  localparam int RANDOM_INSNS   = 120;
  localparam int MIN_RETIRES    = 300;
  localparam int MAX_RETIRES    = 400;
  localparam int RETIRE_TIMEOUT = 20;
  localparam int RESET_TIMEOUT  = 10;

  logic                     clk;
  logic                     rst;
  logic [`CORE_IMEM_AW-1:0] imem_addr;
  logic [`CORE_XLEN-1:0]    imem_rdata;
  retire_t                  retire;

  logic [`CORE_XLEN-1:0] imem [IMEM_WORDS];
  logic [`CORE_XLEN-1:0] m_regs [`CORE_REG_COUNT];
  logic [`CORE_XLEN-1:0] m_pc;
  logic [`CORE_XLEN-1:0] self_jump_pc;
  logic [31:0]           rng;
  int                    wp;

  tb_clock_gen u_clk_gen (
    .clk_o (clk),
    .rst_o (rst)
  );

  pipe_core u_dut (
    .clk_i        (clk),
    .rst_i        (rst),
    .imem_rdata_i (imem_rdata),
    .imem_addr_o  (imem_addr),
    .retire_o     (retire)
  );

  bind pipe_core core_props u_props (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .imem_addr_i (imem_addr_o),
    .retire_i    (retire_o)
  );

  // combinational instruction memory
  assign imem_rdata = imem[imem_addr];

  ////////////////////////////////////////////////////////////////////////////
  // failure reporting and waits
  ////////////////////////////////////////////////////////////////////////////

  task automatic report_mismatch(input string field, input logic [31:0] got,
                                 input logic [31:0] expected);
    $display("Fail at %0t: retire %s is %h, expected %h", $time, field, got, expected);
    $display("TESTS FAILED");
    $fatal(1, "retire mismatch");
  endtask

  task automatic abort_run(input string why);
    $display("Error at %0t: %s", $time, why);
    $display("TESTS FAILED");
    $fatal(1, "run aborted");
  endtask

  // failures counted by the bound property checker
  function automatic int prop_failures();
    return u_dut.u_props.reset_errs + u_dut.u_props.x0_errs + u_dut.u_props.pc_errs;
  endfunction

  // a failed property ends the run at the next falling edge
  always @(negedge clk) begin
    if (prop_failures() != 0) begin
      abort_run("a bound property assertion failed");
    end
  end

  // next valid retire, sampled half a cycle after the rising edge
  task automatic wait_retire();
    int waited;
    waited = 0;
    @(negedge clk);
    while (retire.valid !== 1'b1) begin
      waited++;
      if (waited > RETIRE_TIMEOUT) begin
        abort_run("no instruction retired within the timeout");
      end
      @(negedge clk);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // instruction encoders and program
  ////////////////////////////////////////////////////////////////////////////

  function automatic logic [31:0] xorshift(input logic [31:0] state);
    logic [31:0] x;
    x = state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] enc_r(input int f3, input int f7, input int rd,
                                        input int rs1, input int rs2);
    return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], OPC_OP};
  endfunction

  function automatic logic [31:0] enc_i(input logic [6:0] opc, input int f3, input int rd,
                                        input int rs1, input int imm);
    return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], opc};
  endfunction

  function automatic logic [31:0] enc_u(input logic [6:0] opc, input int rd, input int imm);
    return {imm[19:0], rd[4:0], opc};
  endfunction

  function automatic logic [31:0] enc_b(input int f3, input int rs1, input int rs2,
                                        input int off);
    return {off[12], off[10:5], rs2[4:0], rs1[4:0], f3[2:0], off[4:1], off[11], OPC_BRANCH};
  endfunction

  function automatic logic [31:0] enc_j(input int rd, input int off);
    return {off[20], off[10:1], off[11], off[19:12], rd[4:0], OPC_JAL};
  endfunction

  task automatic emit(input logic [31:0] word);
    imem[wp] = word;
    wp++;
  endtask

  task automatic build_program();
    logic [31:0] r;
    int          kind;
    int          rd;
    int          rs1;
    int          rs2;
    int          f3;
    int          f7;
    int          imm;
    int          ta;
    // unused words hold addi x0, x0, <word index>
    for (int i = 0; i < IMEM_WORDS; i++) begin
      imem[i] = enc_i(OPC_OP_IMM, 0, 0, 0, i);
    end
    rng = 32'h91b3_6d70;
    wp  = 0;
    // random alu, lui and auipc over x0..x7
    for (int n = 0; n < RANDOM_INSNS; n++) begin
      rng  = xorshift(rng);
      r    = rng;
      kind = int'(r[2:0]);
      rd   = int'(r[5:3]);
      rs1  = int'(r[8:6]);
      rs2  = int'(r[11:9]);
      f3   = int'(r[14:12]);
      if (kind < 3) begin
        f7 = ((f3 == 0 || f3 == 5) && r[15]) ? 32 : 0;
        emit(enc_r(f3, f7, rd, rs1, rs2));
      end else if (kind < 6) begin
        if (f3 == 1) begin
          imm = int'(r[24:20]);
        end else if (f3 == 5) begin
          // bit 10 of the immediate picks srai
          imm = int'(r[24:20]) + (r[15] ? 1024 : 0);
        end else begin
          imm = int'(r[31:20]);
        end
        emit(enc_i(OPC_OP_IMM, f3, rd, rs1, imm));
      end else begin
        emit(enc_u(kind == 6 ? OPC_LUI : OPC_AUIPC, rd, int'(r[31:12])));
      end
    end
    // countdown loop on x5
    emit(enc_i(OPC_OP_IMM, 0, 5, 0, 5));
    emit(enc_i(OPC_OP_IMM, 0, 5, 5, -1));
    emit(enc_b(1, 5, 0, -4));
    // x1 = 7 and x2 = -3 make each compare taken one way and not the other
    emit(enc_i(OPC_OP_IMM, 0, 1, 0, 7));
    emit(enc_i(OPC_OP_IMM, 0, 2, 0, -3));
    for (int k = 0; k < 3; k++) begin
      f3 = (k == 0) ? 0 : (k == 1) ? 4 : 7;
      ta = (k == 0) ? 1 : 2;
      emit(enc_b(f3, ta, 1, 8));
      emit(enc_i(OPC_OP_IMM, 0, 3, 3, 1));
      emit(enc_b(f3, 1, 2, 8));
      emit(enc_i(OPC_OP_IMM, 0, 3, 3, 1));
      // hop over, branch back to the landing word, then hop past the backward branch
      emit(enc_b(0, 0, 0, 12));
      emit(enc_i(OPC_OP_IMM, 0, 4, 4, k + 1));
      emit(enc_b(0, 0, 0, 8));
      emit(enc_b(f3, ta, 1, -8));
    end
    // jal and jalr linking through x6, x7 and x1
    emit(enc_j(6, 12));
    emit(enc_i(OPC_OP_IMM, 0, 3, 3, 2));
    emit(enc_j(0, 12));
    emit(enc_i(OPC_JALR, 0, 7, 6, 1));
    emit(enc_i(OPC_OP_IMM, 0, 3, 3, 16));
    emit(enc_i(OPC_JALR, 0, 1, 7, 12));
    emit(enc_i(OPC_OP_IMM, 0, 3, 3, 32));
    emit(enc_r(0, 0, 2, 1, 7));
    self_jump_pc = 32'(wp * 4);
    emit(enc_j(0, 0));
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // instruction-set reference model
  ////////////////////////////////////////////////////////////////////////////

  task automatic model_step(output logic [31:0] insn, output logic [4:0] rd,
                            output logic [31:0] wdata);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_i;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;
    logic [31:0] next_pc;
    logic [31:0] val;
    logic [2:0]  f3;
    logic        wr;
    logic        cond;
    insn    = imem[m_pc[`CORE_IMEM_AW+1:2]];
    f3      = insn[14:12];
    a       = m_regs[insn[19:15]];
    b       = m_regs[insn[24:20]];
    imm_i   = {{20{insn[31]}}, insn[31:20]};
    imm_b   = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
    imm_u   = {insn[31:12], 12'b0};
    imm_j   = {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};
    next_pc = m_pc + 4;
    val     = '0;
    wr      = 1'b0;
    cond    = 1'b0;
    case (insn[6:0])
      OPC_OP, OPC_OP_IMM: begin
        if (insn[6:0] == OPC_OP_IMM) begin
          b = imm_i;
        end
        wr = 1'b1;
        case (f3)
          3'b000: val = (insn[6:0] == OPC_OP && insn[30]) ? a - b : a + b;
          3'b001: val = a << b[4:0];
          3'b010: val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
          3'b011: val = (a < b) ? 32'd1 : 32'd0;
          3'b100: val = a ^ b;
          3'b101: begin
            if (insn[30]) begin
              val = $signed(a) >>> b[4:0];
            end else begin
              val = a >> b[4:0];
            end
          end
          3'b110: val = a | b;
          default: val = a & b;
        endcase
      end
      OPC_LUI: begin
        wr  = 1'b1;
        val = imm_u;
      end
      OPC_AUIPC: begin
        wr  = 1'b1;
        val = m_pc + imm_u;
      end
      OPC_JAL: begin
        wr      = 1'b1;
        val     = m_pc + 4;
        next_pc = m_pc + imm_j;
      end
      OPC_JALR: begin
        wr      = 1'b1;
        val     = m_pc + 4;
        next_pc = (a + imm_i) & ~32'd1;
      end
      OPC_BRANCH: begin
        case (f3)
          3'b000: cond = (a == b);
          3'b001: cond = (a != b);
          3'b100: cond = ($signed(a) < $signed(b));
          3'b101: cond = ($signed(a) >= $signed(b));
          3'b110: cond = (a < b);
          3'b111: cond = (a >= b);
          default: cond = 1'b0;
        endcase
        if (cond) begin
          next_pc = m_pc + imm_b;
        end
      end
      default: ;
    endcase
    rd    = (wr && insn[11:7] != 5'd0) ? insn[11:7] : 5'd0;
    wdata = (rd != 5'd0) ? val : 32'd0;
    if (rd != 5'd0) begin
      m_regs[rd] = val;
    end
    m_pc = next_pc;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // retire checks
  ////////////////////////////////////////////////////////////////////////////

  initial begin : run
    logic [31:0] exp_pc;
    logic [31:0] exp_insn;
    logic [4:0]  exp_rd;
    logic [31:0] exp_wdata;
    int          retired;
    int          waited;
    int          prop_errors;
    bit          done;
    build_program();
    m_pc = `CORE_RESET_PC;
    for (int i = 0; i < `CORE_REG_COUNT; i++) begin
      m_regs[i] = '0;
    end
    waited = 0;
    while (rst !== 1'b0) begin
      @(negedge clk);
      waited++;
      if (waited > RESET_TIMEOUT) begin
        abort_run("reset was never released");
      end
    end
    retired = 0;
    done    = 1'b0;
    while (!done) begin
      wait_retire();
      exp_pc = m_pc;
      model_step(exp_insn, exp_rd, exp_wdata);
      assert (retire.pc == exp_pc)
        else report_mismatch("pc", retire.pc, exp_pc);
      assert (retire.insn == exp_insn)
        else report_mismatch("insn", retire.insn, exp_insn);
      assert (retire.rd_addr == exp_rd)
        else report_mismatch("rd_addr", 32'(retire.rd_addr), 32'(exp_rd));
      assert (retire.rd_wdata == exp_wdata)
        else report_mismatch("rd_wdata", retire.rd_wdata, exp_wdata);
      retired++;
      done = (retired >= MIN_RETIRES) && (exp_pc == self_jump_pc);
      if (retired > MAX_RETIRES) begin
        abort_run("the program never settled on its final jump");
      end
    end
    prop_errors = prop_failures();
    if (prop_errors != 0) begin
      $display("Error at %0t: %0d property failures were reported", $time, prop_errors);
      $display("TESTS FAILED");
      $fatal(1, "property failures");
    end else begin
      $display("TESTS PASSED");
      $finish;
    end
  end

endmodule

// File: flist.f
+incdir+.
core_pkg.sv
insn_decoder.sv
reg_file.sv
alu.sv
hazard_unit.sv
pipe_core.sv
core_props.sv
tb_clock_gen.sv
tb_core.sv

// File: run_sim.sh
#!/bin/sh
# build the core testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f flist.f --top-module tb_core \
  --Mdir obj_dir -o sim_tb_core
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/sim_tb_core +verilator+error+limit+100 > "$LOG" 2>&1
status=$?

if grep -q "TESTS FAILED" "$LOG"; then
  echo "simulation reported a failure, see $LOG"
  exit 1
fi
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status, see $LOG"
  exit 1
fi
echo "simulation finished without failures"
exit 0
